/* tcb_macros.svh */
//////////////////////////////////////////////////////////////////////
// bus subsystem dimensions
// manager count, bus widths and memory size shared by all blocks
//////////////////////////////////////////////////////////////////////

`ifndef TCB_MACROS_SVH
`define TCB_MACROS_SVH

// number of managers sharing the memory
`define TCB_IFN 3

// byte address width
`define TCB_ADR 16

// data width and number of byte lanes
`define TCB_DAT 32
`define TCB_BYT (`TCB_DAT/8)

// memory size in words
`define TCB_MEM_DEPTH 256

`endif

/* tcb_bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// bus field types
// request and response fields of the tightly coupled bus
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

package tcb_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // request fields
    //////////////////////////////////////////////////////////////////////

    // byte address
    typedef logic [`TCB_ADR-1:0] tcb_adr_t;

    // byte enables, one per lane
    typedef logic [`TCB_BYT-1:0] tcb_byt_t;

    // write data, also read data
    typedef logic [`TCB_DAT-1:0] tcb_dat_t;

    //////////////////////////////////////////////////////////////////////
    // interconnect
    //////////////////////////////////////////////////////////////////////

    // manager index for arbiter and multiplexer
    typedef logic [$clog2(`TCB_IFN)-1:0] tcb_sel_t;

endpackage : tcb_bus_pkg

`default_nettype wire

/* tcb_mem_pkg.sv */
//////////////////////////////////////////////////////////////////////
// memory storage types
// one memory word, seen whole or as byte lanes
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

package tcb_mem_pkg;

    // whole word view for reads,
    // byte lane view for merging partial writes
    typedef union packed {
        tcb_bus_pkg::tcb_dat_t       wrd;
        logic [`TCB_BYT-1:0][7:0]    bte;
    } mem_word_u;

endpackage : tcb_mem_pkg

`default_nettype wire

/* tcb_arbiter.sv */
//////////////////////////////////////////////////////////////////////
// round-robin arbiter
// picks one requesting manager, holds the grant for a locked owner
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

module tcb_arbiter (
    input  logic                  man,
    input  logic                  rst,
    input  logic                  vld [`TCB_IFN-1:0],
    input  logic                  lck [`TCB_IFN-1:0],
    input  logic                  trn,
    output tcb_bus_pkg::tcb_sel_t sel
);

    import tcb_bus_pkg::*;

    // search start, one past the last winner
    tcb_sel_t ptr;
    // lock owner and lock flag
    tcb_sel_t lck_sel;
    logic     lck_q;
    // winner of the round-robin search
    tcb_sel_t rr_sel;
    // requests as a packed vector
    logic [`TCB_IFN-1:0] req;

    //////////////////////////////////////////////////////////////////////
    // round-robin search
    //////////////////////////////////////////////////////////////////////

    always_comb begin : rr_search
        int unsigned idx;
        logic        found;
        found  = 1'b0;
        rr_sel = ptr;
        for (int unsigned k = 0; k < `TCB_IFN; k++) begin
            // wrap around the manager count
            idx = (int'(ptr) + k) % `TCB_IFN;
            req[k] = vld[k];
            if (!found && vld[idx]) begin
                found  = 1'b1;
                rr_sel = tcb_sel_t'(idx);
            end
        end
    end

    // locked owner wins over the search
    assign sel = lck_q ? lck_sel : rr_sel;

    //////////////////////////////////////////////////////////////////////
    // pointer and lock
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge man) begin
        if (rst) begin
            ptr     <= '0;
            lck_q   <= 1'b0;
            lck_sel <= '0;
        end else if (trn) begin
            // next search starts after the winner
            ptr     <= (int'(sel) == `TCB_IFN-1) ? '0 : sel + 1'b1;
            // lock taken or released on every transfer
            lck_q   <= lck[sel];
            lck_sel <= sel;
        end
    end

    // without a lock the grant goes to a requester
    a_sel_req : assert property (@(posedge man) disable iff (rst)
        !lck_q && (|req) |-> vld[sel]);

    // locked transfer keeps the grant on the next cycle
    a_lck_hold : assert property (@(posedge man) disable iff (rst)
        trn && lck[sel] |=> sel == $past(sel));

endmodule : tcb_arbiter

`default_nettype wire

/* tcb_multiplexer.sv */
//////////////////////////////////////////////////////////////////////
// request multiplexer
// routes the selected manager to the memory port, sends ready to it
// and returns the response one cycle later by a registered select
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

module tcb_multiplexer (
    input  logic                  man,
    input  logic                  rst,
    input  tcb_bus_pkg::tcb_sel_t sel,
    // manager side, one entry per manager
    input  logic                  sub_vld [`TCB_IFN-1:0],
    input  logic                  sub_wen [`TCB_IFN-1:0],
    input  logic                  sub_ren [`TCB_IFN-1:0],
    input  tcb_bus_pkg::tcb_adr_t sub_adr [`TCB_IFN-1:0],
    input  tcb_bus_pkg::tcb_byt_t sub_byt [`TCB_IFN-1:0],
    input  tcb_bus_pkg::tcb_dat_t sub_wdt [`TCB_IFN-1:0],
    output logic                  sub_rdy [`TCB_IFN-1:0],
    output tcb_bus_pkg::tcb_dat_t sub_rdt [`TCB_IFN-1:0],
    output logic                  sub_err [`TCB_IFN-1:0],
    // subordinate side
    output logic                  man_vld,
    output logic                  man_wen,
    output logic                  man_ren,
    output tcb_bus_pkg::tcb_adr_t man_adr,
    output tcb_bus_pkg::tcb_byt_t man_byt,
    output tcb_bus_pkg::tcb_dat_t man_wdt,
    input  logic                  man_rdy,
    input  tcb_bus_pkg::tcb_dat_t man_rdt,
    input  logic                  man_err,
    output logic                  trn
);

    import tcb_bus_pkg::*;

    // select of the manager owning the pending response
    tcb_sel_t rsp_sel;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    // transfer on the subordinate port
    assign trn = man_vld & man_rdy;

    // response follows the transfer by one cycle
    always_ff @(posedge man) begin
        if (rst) begin
            rsp_sel <= '0;
        end else if (trn) begin
            rsp_sel <= sel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // request
    //////////////////////////////////////////////////////////////////////

    // zero latency path from the selected manager
    assign man_vld = sub_vld[sel];
    assign man_wen = sub_wen[sel];
    assign man_ren = sub_ren[sel];
    assign man_adr = sub_adr[sel];
    assign man_byt = sub_byt[sel];
    assign man_wdt = sub_wdt[sel];

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `TCB_IFN; i++) begin : gen_rsp
        // read data shared by all managers
        assign sub_rdt[i] = man_rdt;
        // error only for the owner of the response
        assign sub_err[i] = (rsp_sel == tcb_sel_t'(i)) ? man_err : 1'b0;
        // ready only for the manager being served now
        assign sub_rdy[i] = (sel == tcb_sel_t'(i)) ? man_rdy : 1'b0;
    end : gen_rsp

    // select never points past the last manager
    a_sel_range : assert property (@(posedge man) disable iff (rst)
        int'(sel) < `TCB_IFN);

endmodule : tcb_multiplexer

`default_nettype wire

/* tcb_memory.sv */
//////////////////////////////////////////////////////////////////////
// single-cycle SRAM subordinate
// byte-enabled writes, registered reads, error past the last word
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

module tcb_memory (
    input  logic                  man,
    input  logic                  rst,
    input  logic                  vld,
    input  logic                  wen,
    input  logic                  ren,
    input  tcb_bus_pkg::tcb_adr_t adr,
    input  tcb_bus_pkg::tcb_byt_t byt,
    input  tcb_bus_pkg::tcb_dat_t wdt,
    output logic                  rdy,
    output tcb_bus_pkg::tcb_dat_t rdt,
    output logic                  err
);

    import tcb_mem_pkg::*;

    // word offset inside a byte address
    localparam int unsigned ADR_LSB = $clog2(`TCB_BYT);
    // word index width
    localparam int unsigned IDX_W = $clog2(`TCB_MEM_DEPTH);
    // first byte address past the array
    localparam logic [`TCB_ADR-1:0] ADR_LIM = `TCB_ADR'(`TCB_MEM_DEPTH * `TCB_BYT);

    // storage
    mem_word_u mem [0:`TCB_MEM_DEPTH-1];

    logic             trn;
    logic             oor;
    logic [IDX_W-1:0] idx;
    // write data and merged word
    mem_word_u        wdt_u;
    mem_word_u        wr_word;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    assign trn = vld & rdy;
    // out of range
    assign oor = (adr >= ADR_LIM);
    // word index, byte offset dropped
    assign idx = adr[ADR_LSB +: IDX_W];

    //////////////////////////////////////////////////////////////////////
    // write
    //////////////////////////////////////////////////////////////////////

    // merge enabled lanes into the stored word
    always_comb begin
        wdt_u.wrd = wdt;
        wr_word   = mem[idx];
        for (int b = 0; b < `TCB_BYT; b++) begin
            if (byt[b]) begin
                wr_word.bte[b] = wdt_u.bte[b];
            end
        end
    end

    always_ff @(posedge man) begin
        // nothing stored past the array
        if (trn && wen && !oor) begin
            mem[idx] <= wr_word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read and response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge man) begin
        if (trn && oor) begin
            // error returns zero data
            rdt <= '0;
        end else if (trn && ren) begin
            rdt <= mem[idx].wrd;
        end
    end

    always_ff @(posedge man) begin
        if (rst) begin
            rdy <= 1'b0;
            err <= 1'b0;
        end else begin
            // ready from the first cycle out of reset
            rdy <= 1'b1;
            // error lasts one cycle
            err <= trn & oor;
        end
    end

    // a transfer is a read or a write, never both
    a_rw_excl : assert property (@(posedge man) disable iff (rst)
        trn |-> !(wen && ren));

endmodule : tcb_memory

`default_nettype wire

/* tcb_subsystem.sv */
//////////////////////////////////////////////////////////////////////
// bus subsystem top level
// managers share one SRAM through arbiter and multiplexer
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

module tcb_subsystem (
    input  logic                  man,
    input  logic                  rst,
    // manager ports
    input  logic                  vld [`TCB_IFN-1:0],
    input  logic                  lck [`TCB_IFN-1:0],
    input  logic                  wen [`TCB_IFN-1:0],
    input  logic                  ren [`TCB_IFN-1:0],
    input  tcb_bus_pkg::tcb_adr_t adr [`TCB_IFN-1:0],
    input  tcb_bus_pkg::tcb_byt_t byt [`TCB_IFN-1:0],
    input  tcb_bus_pkg::tcb_dat_t wdt [`TCB_IFN-1:0],
    output logic                  rdy [`TCB_IFN-1:0],
    output tcb_bus_pkg::tcb_dat_t rdt [`TCB_IFN-1:0],
    output logic                  err [`TCB_IFN-1:0]
);

    import tcb_bus_pkg::*;

    // arbitration
    tcb_sel_t sel;
    logic     trn;

    // memory port
    logic     mem_vld;
    logic     mem_wen;
    logic     mem_ren;
    tcb_adr_t mem_adr;
    tcb_byt_t mem_byt;
    tcb_dat_t mem_wdt;
    logic     mem_rdy;
    tcb_dat_t mem_rdt;
    logic     mem_err;

    //////////////////////////////////////////////////////////////////////
    // arbiter
    //////////////////////////////////////////////////////////////////////

    tcb_arbiter arb0 (
        .man (man),
        .rst (rst),
        .vld (vld),
        .lck (lck),
        .trn (trn),
        .sel (sel)
    );

    //////////////////////////////////////////////////////////////////////
    // multiplexer
    //////////////////////////////////////////////////////////////////////

    tcb_multiplexer mux0 (
        .man     (man),
        .rst     (rst),
        .sel     (sel),
        .sub_vld (vld),
        .sub_wen (wen),
        .sub_ren (ren),
        .sub_adr (adr),
        .sub_byt (byt),
        .sub_wdt (wdt),
        .sub_rdy (rdy),
        .sub_rdt (rdt),
        .sub_err (err),
        .man_vld (mem_vld),
        .man_wen (mem_wen),
        .man_ren (mem_ren),
        .man_adr (mem_adr),
        .man_byt (mem_byt),
        .man_wdt (mem_wdt),
        .man_rdy (mem_rdy),
        .man_rdt (mem_rdt),
        .man_err (mem_err),
        .trn     (trn)
    );

    //////////////////////////////////////////////////////////////////////
    // memory
    //////////////////////////////////////////////////////////////////////

    tcb_memory mem0 (
        .man (man),
        .rst (rst),
        .vld (mem_vld),
        .wen (mem_wen),
        .ren (mem_ren),
        .adr (mem_adr),
        .byt (mem_byt),
        .wdt (mem_wdt),
        .rdy (mem_rdy),
        .rdt (mem_rdt),
        .err (mem_err)
    );

endmodule : tcb_subsystem

`default_nettype wire

/* tb_clock.sv */
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// period of 100, reset high for the first 4 rising edges
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_clock (
    output logic man,
    output logic rst
);

    initial begin
        man = 1'b0;
        forever #50 man = ~man;
    end

    // release a little after the 4th edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge man);
        #10;
        rst = 1'b0;
    end

endmodule : tb_clock

`default_nettype wire

/* tb_tcb_subsystem.sv */
//////////////////////////////////////////////////////////////////////
// bus subsystem testbench
// shadow memory and arbiter model give the expected values
// for the checking assertions
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_macros.svh"

module tb_tcb_subsystem;

    import tcb_bus_pkg::*;

    localparam int N = `TCB_IFN;
    localparam int MEM_BYTES = `TCB_MEM_DEPTH * `TCB_BYT;
    // longest wait for rdy
    localparam int WAIT_MAX = 40;

    logic         man;
    logic         rst;
    logic         rst_q = 1'b0;
    logic         vld [N-1:0];
    logic         lck [N-1:0];
    logic         wen [N-1:0];
    logic         ren [N-1:0];
    tcb_adr_t     adr [N-1:0];
    tcb_byt_t     byt [N-1:0];
    tcb_dat_t     wdt [N-1:0];
    logic         rdy [N-1:0];
    tcb_dat_t     rdt [N-1:0];
    logic         err [N-1:0];
    logic [N-1:0] rdy_vec;
    logic [N-1:0] err_vec;
    // byte shadow of the SRAM
    logic [7:0]   shadow [0:MEM_BYTES-1];
    // arbiter model: pointer, lock flag and owner
    int unsigned  m_ptr;
    int unsigned  m_own;
    logic         m_lck;
    int unsigned  exp_win;
    logic         any_req;
    // transfer seen before the edge, checks due one edge later
    logic         xfer    [N-1:0];
    logic         chk_rsp [N-1:0];
    logic         chk_rd  [N-1:0];
    logic         exp_err [N-1:0];
    tcb_dat_t     exp_rdt [N-1:0];
    int           err_cnt = 0;
    int           tmo_cnt = 0;

    tb_clock clk0 (
        .man (man),
        .rst (rst)
    );

    tcb_subsystem dut0 (
        .man (man),
        .rst (rst),
        .vld (vld),
        .lck (lck),
        .wen (wen),
        .ren (ren),
        .adr (adr),
        .byt (byt),
        .wdt (wdt),
        .rdy (rdy),
        .rdt (rdt),
        .err (err)
    );

    for (genvar g = 0; g < N; g++) begin : gen_vec
        assign rdy_vec[g] = rdy[g];
        assign err_vec[g] = err[g];
    end : gen_vec

    //////////////////////////////////////////////////////////////////////
    // models
    //////////////////////////////////////////////////////////////////////

    // stable point between edges, expected winner and transfers
    always @(negedge man) begin : snapshot
        int unsigned idx;
        logic        found;
        found   = 1'b0;
        any_req = 1'b0;
        exp_win = m_ptr;
        for (int k = 0; k < N; k++) begin
            xfer[k] = vld[k] && rdy[k];
            any_req = any_req | vld[k];
            idx = (m_ptr + k) % N;
            if (!found && vld[idx]) begin
                found   = 1'b1;
                exp_win = idx;
            end
        end
        // lock owner wins outright
        if (m_lck) begin
            exp_win = m_own;
        end
    end

    always @(posedge man) begin : monitor
        int unsigned wi;
        logic        oor;
        rst_q <= rst;
        for (int i = 0; i < N; i++) begin
            chk_rsp[i] <= 1'b0;
            chk_rd[i]  <= 1'b0;
        end
        if (rst) begin
            m_ptr = 0;
            m_own = 0;
            m_lck = 1'b0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (xfer[i]) begin
                    oor = int'(adr[i]) >= MEM_BYTES;
                    wi  = int'(adr[i]) / `TCB_BYT;
                    chk_rsp[i] <= 1'b1;
                    chk_rd[i]  <= ren[i];
                    exp_err[i] <= oor;
                    exp_rdt[i] <= '0;
                    if (!oor) begin
                        // lane b sits at byte address wi*BYT+b
                        for (int b = 0; b < `TCB_BYT; b++) begin
                            exp_rdt[i][8*b +: 8] <= shadow[wi*`TCB_BYT + b];
                            if (wen[i] && byt[i][b]) begin
                                shadow[wi*`TCB_BYT + b] = wdt[i][8*b +: 8];
                            end
                        end
                    end
                    m_ptr = (i + 1) % N;
                    m_own = i;
                    m_lck = lck[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < N; g++) begin : gen_chk
        a_read_data : assert property (@(posedge man) disable iff (rst)
            chk_rd[g] |-> rdt[g] == exp_rdt[g])
        else begin
            err_cnt++;
            $display("[ERROR] read_data m%0d: expected %h, actual %h",
                g, $sampled(exp_rdt[g]), $sampled(rdt[g]));
        end
        // err only on the issuing manager, one cycle after
        a_resp_err : assert property (@(posedge man) disable iff (rst)
            err[g] == (chk_rsp[g] && exp_err[g]))
        else begin
            err_cnt++;
            $display("[ERROR] resp_err m%0d: expected %b, actual %b",
                g, $sampled(chk_rsp[g] && exp_err[g]), $sampled(err[g]));
        end
    end : gen_chk

    // rotation and lock, rdy for the winner only
    a_grant : assert property (@(posedge man) disable iff (rst || rst_q)
        any_req |-> rdy_vec == (N'(1) << exp_win))
    else begin
        err_cnt++;
        $display("[ERROR] grant: expected %b, actual %b",
            $sampled(N'(1) << exp_win), $sampled(rdy_vec));
    end

    a_reset_quiet : assert property (@(posedge man)
        rst_q |-> rdy_vec == '0 && err_vec == '0)
    else begin
        err_cnt++;
        $display("[ERROR] reset_quiet: expected %b, actual %b",
            {2*N{1'b0}}, $sampled({rdy_vec, err_vec}));
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // one request held until rdy, called just after a rising edge
    task automatic run_xfer(input int m, input logic w, input logic l, input int unsigned a,
                            input tcb_byt_t b, input tcb_dat_t d);
        int   cnt;
        logic done;
        cnt  = 0;
        done = 1'b0;
        vld[m] = 1'b1;
        lck[m] = l;
        wen[m] = w;
        ren[m] = !w;
        adr[m] = tcb_adr_t'(a);
        byt[m] = b;
        wdt[m] = d;
        while (!done && cnt < WAIT_MAX) begin
            @(negedge man);
            done = rdy[m];
            cnt++;
            @(posedge man);
            #10;
        end
        if (!done) begin
            tmo_cnt++;
            $display("timeout: manager %0d never got rdy", m);
        end
        vld[m] = 1'b0;
        lck[m] = 1'b0;
        wen[m] = 1'b0;
        ren[m] = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge man);
            #10;
        end
    endtask

    task automatic write_burst(input int m);
        for (int k = 0; k < 4; k++) begin
            run_xfer(m, 1'b1, 1'b0, (200 + 4*m + k) * 4, '1, tcb_dat_t'($urandom));
        end
    endtask

    initial begin : stimulus
        int unsigned wi [N-1:0];
        int          cnt;
        void'($urandom(45070));
        for (int m = 0; m < N; m++) begin
            vld[m] = 1'b0;
            lck[m] = 1'b0;
            wen[m] = 1'b0;
            ren[m] = 1'b0;
            adr[m] = '0;
            byt[m] = '0;
            wdt[m] = '0;
        end
        for (int b = 0; b < MEM_BYTES; b++) begin
            shadow[b] = 8'h00;
        end
        cnt = 0;
        do begin
            @(negedge man);
            cnt++;
        end while (rst && cnt < WAIT_MAX);
        if (rst) begin
            tmo_cnt++;
            $display("timeout: reset was never released");
        end
        wait_cycles(3);
        // write and read back, then byte enables on the next word
        for (int m = 0; m < N; m++) begin
            wi[m] = m * 64 + $urandom % 60;
            run_xfer(m, 1'b1, 1'b0, wi[m] * 4, '1, tcb_dat_t'($urandom));
            run_xfer(m, 1'b0, 1'b0, wi[m] * 4, '1, '0);
            run_xfer(m, 1'b1, 1'b0, wi[m] * 4 + 4, '1, tcb_dat_t'($urandom));
            for (int k = 0; k < 4; k++) begin
                run_xfer(m, 1'b1, 1'b0, wi[m] * 4 + 4, tcb_byt_t'($urandom),
                         tcb_dat_t'($urandom));
            end
            run_xfer(m, 1'b0, 1'b0, wi[m] * 4 + 4, '1, '0);
        end
        // out of range write aliasing a used word, out of range read, then recheck
        for (int m = 0; m < N; m++) begin
            run_xfer(m, 1'b1, 1'b0, MEM_BYTES + wi[m] * 4, '1, tcb_dat_t'($urandom));
            run_xfer(m, 1'b0, 1'b0, MEM_BYTES + 4 * ($urandom % 1000), '1, '0);
            run_xfer(m, 1'b0, 1'b0, wi[m] * 4, '1, '0);
        end
        // all managers at once, no lock
        fork
            write_burst(0);
            write_burst(1);
            write_burst(2);
        join
        for (int k = 0; k < 4 * N; k++) begin
            run_xfer(k % N, 1'b0, 1'b0, (200 + k) * 4, '1, '0);
        end
        // manager 0 locks, others wait for its second request
        fork
            begin
                run_xfer(0, 1'b1, 1'b1, 240 * 4, '1, tcb_dat_t'($urandom));
                run_xfer(0, 1'b1, 1'b0, 241 * 4, '1, tcb_dat_t'($urandom));
            end
            begin
                wait_cycles(1);
                run_xfer(1, 1'b0, 1'b0, 240 * 4, '1, '0);
            end
            begin
                wait_cycles(1);
                run_xfer(2, 1'b0, 1'b0, 241 * 4, '1, '0);
            end
        join
        wait_cycles(3);
        $display("assertion errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_tcb_subsystem

`default_nettype wire

/* build.f */
+incdir+.
tcb_bus_pkg.sv
tcb_mem_pkg.sv
tcb_arbiter.sv
tcb_multiplexer.sv
tcb_memory.sv
tcb_subsystem.sv
tb_clock.sv
tb_tcb_subsystem.sv

/* Bender.yml */
package:
  name: tcb_subsystem

export_include_dirs:
  - .

sources:
  - tcb_bus_pkg.sv
  - tcb_mem_pkg.sv
  - tcb_arbiter.sv
  - tcb_multiplexer.sv
  - tcb_memory.sv
  - tcb_subsystem.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_tcb_subsystem.sv
